// ==== verilog/loongarch_pkg.sv ====
`default_nettype none

package loongarch_pkg;

    // page size codes as carried in the ps field of an entry
    localparam int unsigned ps_4k = 12;
    localparam int unsigned ps_2m = 21;

    // privilege levels, plv0 is the most privileged
    typedef enum logic [1:0] {
        plv0 = 2'd0,
        plv1 = 2'd1,
        plv2 = 2'd2,
        plv3 = 2'd3
    } plv_e;

    // memory access types
    // suc strongly-ordered uncached, cc coherent cached, wuc weakly-ordered uncached
    typedef enum logic [1:0] {
        mat_suc  = 2'd0,
        mat_cc   = 2'd1,
        mat_wuc  = 2'd2,
        mat_rsvd = 2'd3
    } mat_e;

    // invtlb opcodes, anything above 6 is undefined
    typedef enum logic [4:0] {
        inv_all0      = 5'd0,
        inv_all1      = 5'd1,
        inv_global    = 5'd2,
        inv_nonglobal = 5'd3,
        inv_asid      = 5'd4,
        inv_asid_va   = 5'd5,
        inv_gasid_va  = 5'd6
    } invtlb_op_e;

endpackage

`default_nettype wire

// ==== verilog/tlb_pkg.sv ====
`default_nettype none

package tlb_pkg;

    import loongarch_pkg::*;

    // fully associative, one entry per even/odd page pair
    localparam int unsigned tlb_num   = 16;
    localparam int unsigned tlb_idx_w = $clog2(tlb_num);

    // field widths
    localparam int unsigned vppn_w = 19;
    localparam int unsigned asid_w = 10;
    localparam int unsigned ppn_w  = 20;

    // one half of a page pair
    typedef struct packed {
        logic [ppn_w-1:0] ppn;
        plv_e             plv;
        mat_e             mat;
        logic             d;
        logic             v;
    } tlb_page_t;

    // full entry, page0 is the even page and page1 the odd one
    typedef struct packed {
        logic              e;
        logic [vppn_w-1:0] vppn;
        logic [5:0]        ps;
        logic              g;
        logic [asid_w-1:0] asid;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    // search request, shared by fetch, load/store and invtlb
    typedef struct packed {
        logic [vppn_w-1:0] vppn;
        logic              va_bit12;
        logic [asid_w-1:0] asid;
    } tlb_search_req_t;

    // search result, all zero on a miss
    typedef struct packed {
        logic                 found;
        logic [tlb_idx_w-1:0] index;
        logic [ppn_w-1:0]     ppn;
        logic [5:0]           ps;
        plv_e                 plv;
        mat_e                 mat;
        logic                 d;
        logic                 v;
    } tlb_search_res_t;

endpackage

`default_nettype wire

// ==== verilog/tlb_store.sv ====
`default_nettype none

module tlb_store
    import loongarch_pkg::*;
    import tlb_pkg::*;
(
    input  logic                           aclk,
    input  logic                           reset,

    // write port, tlbwr and tlbfill
    input  logic                           tlb_we,
    input  logic [tlb_idx_w-1:0]           w_index,
    input  tlb_entry_t                     w_entry,

    // read port, tlbrd
    input  logic [tlb_idx_w-1:0]           r_index,
    output tlb_entry_t                     r_entry,

    // invtlb, asid and vppn come from search port 1
    input  logic                           invtlb_valid,
    input  invtlb_op_e                     invtlb_op,
    input  tlb_search_req_t                inv_req,

    // whole array for the lookup units
    output tlb_entry_t [tlb_num-1:0]       entries
);

    tlb_entry_t [tlb_num-1:0] entry_q;

    // per-entry compare results against the invtlb request
    logic [tlb_num-1:0] asid_eq;
    logic [tlb_num-1:0] vppn_eq;
    logic [tlb_num-1:0] inv_hit;

    genvar gi;

    generate
        for (gi = 0; gi < tlb_num; gi++) begin : g_inv
            logic is_2m;

            assign is_2m      = entry_q[gi].ps == 6'(ps_2m);
            assign asid_eq[gi] = entry_q[gi].asid == inv_req.asid;

            // a 2 MB entry ignores the low 9 vppn bits
            assign vppn_eq[gi] = is_2m ?
                (entry_q[gi].vppn[vppn_w-1:9] == inv_req.vppn[vppn_w-1:9]) :
                (entry_q[gi].vppn == inv_req.vppn);

            always_comb begin
                case (invtlb_op)
                    inv_all0,
                    inv_all1: begin
                        inv_hit[gi] = 1'b1;
                    end
                    inv_global: begin
                        inv_hit[gi] = entry_q[gi].g;
                    end
                    inv_nonglobal: begin
                        inv_hit[gi] = !entry_q[gi].g;
                    end
                    inv_asid: begin
                        inv_hit[gi] = !entry_q[gi].g && asid_eq[gi];
                    end
                    inv_asid_va: begin
                        inv_hit[gi] = !entry_q[gi].g && asid_eq[gi] && vppn_eq[gi];
                    end
                    inv_gasid_va: begin
                        inv_hit[gi] = (entry_q[gi].g || asid_eq[gi]) && vppn_eq[gi];
                    end
                    // undefined opcodes leave the array alone
                    default: begin
                        inv_hit[gi] = 1'b0;
                    end
                endcase
            end
        end
    endgenerate

    // only the e bits are cleared on reset
    // write is placed last so it wins over a clear on the same edge
    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < tlb_num; i++) begin
                entry_q[i].e <= 1'b0;
            end
        end else begin
            if (invtlb_valid) begin
                for (int i = 0; i < tlb_num; i++) begin
                    if (inv_hit[i]) begin
                        entry_q[i].e <= 1'b0;
                    end
                end
            end
            if (tlb_we) begin
                entry_q[w_index] <= w_entry;
            end
        end
    end

    // read is combinational from the index
    assign r_entry = entry_q[r_index];

    assign entries = entry_q;

endmodule

`default_nettype wire

// ==== verilog/tlb_lookup.sv ====
`default_nettype none

module tlb_lookup
    import loongarch_pkg::*;
    import tlb_pkg::*;
(
    input  tlb_entry_t [tlb_num-1:0] entries,
    input  tlb_search_req_t          req,
    output tlb_search_res_t          res
);

    logic [tlb_num-1:0]   match;
    logic                 hit;
    logic [tlb_idx_w-1:0] hit_idx;
    tlb_entry_t           hit_entry;
    logic                 hit_2m;
    logic                 page_sel;
    tlb_page_t            hit_page;

    genvar gi;

    generate
        for (gi = 0; gi < tlb_num; gi++) begin : g_match
            logic is_2m;
            logic asid_ok;
            logic vppn_ok;

            assign is_2m   = entries[gi].ps == 6'(ps_2m);
            assign asid_ok = entries[gi].g || (entries[gi].asid == req.asid);

            // bits 8 to 0 select within a 2 MB pair and take no part in the tag
            assign vppn_ok = is_2m ?
                (entries[gi].vppn[vppn_w-1:9] == req.vppn[vppn_w-1:9]) :
                (entries[gi].vppn == req.vppn);

            assign match[gi] = entries[gi].e && asid_ok && vppn_ok;
        end
    endgenerate

    assign hit = |match;

    // lowest matching index wins, so scan from the top down
    always_comb begin
        hit_idx = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = tlb_idx_w'(i);
            end
        end
    end

    assign hit_entry = entries[hit_idx];
    assign hit_2m    = hit_entry.ps == 6'(ps_2m);

    // even or odd half of the pair
    assign page_sel = hit_2m ? req.vppn[8] : req.va_bit12;
    assign hit_page = page_sel ? hit_entry.page1 : hit_entry.page0;

    always_comb begin
        res = '0;
        if (hit) begin
            res.found = 1'b1;
            res.index = hit_idx;
            res.ppn   = hit_page.ppn;
            res.ps    = hit_entry.ps;
            res.plv   = hit_page.plv;
            res.mat   = hit_page.mat;
            res.d     = hit_page.d;
            res.v     = hit_page.v;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tlb_top.sv ====
`default_nettype none

module tlb_top
    import loongarch_pkg::*;
    import tlb_pkg::*;
(
    input  logic                 aclk,
    input  logic                 reset,

    // search port 0, fetch
    input  tlb_search_req_t      s0_req,
    output tlb_search_res_t      s0_res,

    // search port 1, load/store and invtlb operands
    input  tlb_search_req_t      s1_req,
    output tlb_search_res_t      s1_res,

    // write port
    input  logic                 tlb_we,
    input  logic [tlb_idx_w-1:0] w_index,
    input  tlb_entry_t           w_entry,

    // read port
    input  logic [tlb_idx_w-1:0] r_index,
    output tlb_entry_t           r_entry,

    // invtlb
    input  logic                 invtlb_valid,
    input  invtlb_op_e           invtlb_op
);

    tlb_entry_t [tlb_num-1:0] entries;

    tlb_store u_store (
        .aclk         (aclk),
        .reset        (reset),
        .tlb_we       (tlb_we),
        .w_index      (w_index),
        .w_entry      (w_entry),
        .r_index      (r_index),
        .r_entry      (r_entry),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .inv_req      (s1_req),
        .entries      (entries)
    );

    // both lookups read the same array
    tlb_lookup u_lookup0 (
        .entries (entries),
        .req     (s0_req),
        .res     (s0_res)
    );

    tlb_lookup u_lookup1 (
        .entries (entries),
        .req     (s1_req),
        .res     (s1_res)
    );

endmodule

`default_nettype wire

// ==== test/tlb_chk.sv ====
`default_nettype none

module tlb_chk
    import loongarch_pkg::*;
    import tlb_pkg::*;
(
    input logic                 aclk,
    input logic                 reset,
    input tlb_search_req_t      s0_req,
    input tlb_search_res_t      s0_res,
    input tlb_search_req_t      s1_req,
    input tlb_search_res_t      s1_res,
    input logic                 tlb_we,
    input logic [tlb_idx_w-1:0] w_index,
    input tlb_entry_t           w_entry,
    input logic [tlb_idx_w-1:0] r_index,
    input tlb_entry_t           r_entry,
    input logic                 invtlb_valid,
    input invtlb_op_e           invtlb_op
);

    tlb_entry_t [tlb_num-1:0] shadow_q;
    tlb_search_res_t          exp0;
    tlb_search_res_t          exp1;
    logic                     reset_q;
    int                       fail_count = 0;

    // tag compare, a 2 MB pair ignores vppn bits 8 to 0
    function automatic logic tag_matches(input tlb_entry_t ent, input logic [vppn_w-1:0] vppn);
        if (ent.ps == 6'(ps_2m)) begin
            return ent.vppn[18:9] == vppn[18:9];
        end
        return ent.vppn == vppn;
    endfunction

    function automatic logic entry_matches(input tlb_entry_t ent, input tlb_search_req_t req);
        return ent.e && (ent.g || ent.asid == req.asid) && tag_matches(ent, req.vppn);
    endfunction

    // which entries an invtlb opcode clears
    function automatic logic inv_clears(input tlb_entry_t ent, input logic [4:0] op,
                                        input tlb_search_req_t req);
        logic asid_eq;
        logic va_eq;
        asid_eq = ent.asid == req.asid;
        va_eq   = tag_matches(ent, req.vppn);
        if (op <= 5'd1) return 1'b1;
        if (op == 5'd2) return ent.g;
        if (op == 5'd3) return !ent.g;
        if (op == 5'd4) return !ent.g && asid_eq;
        if (op == 5'd5) return !ent.g && asid_eq && va_eq;
        if (op == 5'd6) return (ent.g || asid_eq) && va_eq;
        return 1'b0;
    endfunction

    // first match from index 0 up, then the even or odd half
    function automatic tlb_search_res_t expect_res(input tlb_entry_t [tlb_num-1:0] ents,
                                                   input tlb_search_req_t req);
        tlb_search_res_t res;
        tlb_page_t       pg;
        logic            done;
        logic            odd;
        res  = '0;
        done = 1'b0;
        for (int i = 0; i < tlb_num; i++) begin
            if (!done && entry_matches(ents[i], req)) begin
                done      = 1'b1;
                odd       = (ents[i].ps == 6'(ps_2m)) ? req.vppn[8] : req.va_bit12;
                pg        = odd ? ents[i].page1 : ents[i].page0;
                res.found = 1'b1;
                res.index = i[tlb_idx_w-1:0];
                res.ppn   = pg.ppn;
                res.ps    = ents[i].ps;
                res.plv   = pg.plv;
                res.mat   = pg.mat;
                res.d     = pg.d;
                res.v     = pg.v;
            end
        end
        return res;
    endfunction

    // shadow of the entry store, write lands after any clear
    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < tlb_num; i++) begin
                shadow_q[i].e <= 1'b0;
            end
        end else begin
            for (int i = 0; i < tlb_num; i++) begin
                if (invtlb_valid && inv_clears(shadow_q[i], invtlb_op, s1_req)) begin
                    shadow_q[i].e <= 1'b0;
                end
            end
            if (tlb_we) begin
                shadow_q[w_index] <= w_entry;
            end
        end
    end

    always_ff @(posedge aclk) begin
        reset_q <= reset;
    end

    always_comb begin
        exp0 = expect_res(shadow_q, s0_req);
        exp1 = expect_res(shadow_q, s1_req);
    end

    // sampled mid-cycle, where requests and entries are settled
    a_s0_res: assert property (@(negedge aclk) disable iff (reset) s0_res == exp0)
        else begin
            $error("s0_res expected %h, got %h", exp0, s0_res);
            fail_count++;
        end

    a_s1_res: assert property (@(negedge aclk) disable iff (reset) s1_res == exp1)
        else begin
            $error("s1_res expected %h, got %h", exp1, s1_res);
            fail_count++;
        end

    a_miss_after_reset: assert property (@(negedge aclk)
        reset_q |-> (!s0_res.found && !s1_res.found))
        else begin
            $error("a search hit right after reset");
            fail_count++;
        end

    a_read_valid: assert property (@(negedge aclk) disable iff (reset)
        shadow_q[r_index].e |-> r_entry == shadow_q[r_index])
        else begin
            $error("r_entry expected %h, got %h", shadow_q[r_index], r_entry);
            fail_count++;
        end

    a_read_cleared: assert property (@(negedge aclk) disable iff (reset)
        !shadow_q[r_index].e |-> !r_entry.e)
        else begin
            $error("r_entry.e set on an entry that should be invalid");
            fail_count++;
        end

endmodule

bind tlb_top tlb_chk u_chk (
    .aclk         (aclk),
    .reset        (reset),
    .s0_req       (s0_req),
    .s0_res       (s0_res),
    .s1_req       (s1_req),
    .s1_res       (s1_res),
    .tlb_we       (tlb_we),
    .w_index      (w_index),
    .w_entry      (w_entry),
    .r_index      (r_index),
    .r_entry      (r_entry),
    .invtlb_valid (invtlb_valid),
    .invtlb_op    (invtlb_op)
);

`default_nettype wire

// ==== test/tlb_tb.sv ====
`default_nettype none

module tlb_tb
    import loongarch_pkg::*;
    import tlb_pkg::*;
();

    localparam int max_cycles = 3000;

    logic                 aclk;
    logic                 reset;
    tlb_search_req_t      s0_req;
    tlb_search_res_t      s0_res;
    tlb_search_req_t      s1_req;
    tlb_search_res_t      s1_res;
    logic                 tlb_we;
    logic [tlb_idx_w-1:0] w_index;
    tlb_entry_t           w_entry;
    logic [tlb_idx_w-1:0] r_index;
    tlb_entry_t           r_entry;
    logic                 invtlb_valid;
    invtlb_op_e           invtlb_op;

    integer            seed = 32'h569e6647;
    int                errors = 0;
    int                cycles = 0;
    int                total;
    tlb_entry_t        written [tlb_num];
    logic [vppn_w-1:0] pool_vppn [4];
    logic [asid_w-1:0] pool_asid [2];
    logic [vppn_w-1:0] va;
    logic [asid_w-1:0] asid_a;
    logic [31:0]       r;

    tlb_top DUT (
        .aclk         (aclk),
        .reset        (reset),
        .s0_req       (s0_req),
        .s0_res       (s0_res),
        .s1_req       (s1_req),
        .s1_res       (s1_res),
        .tlb_we       (tlb_we),
        .w_index      (w_index),
        .w_entry      (w_entry),
        .r_index      (r_index),
        .r_entry      (r_entry),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the test did not finish within %0d cycles", max_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic tlb_search_req_t make_req(input logic [vppn_w-1:0] vppn,
                                                 input logic bit12, input logic [asid_w-1:0] asid);
        tlb_search_req_t q;
        q.vppn     = vppn;
        q.va_bit12 = bit12;
        q.asid     = asid;
        return q;
    endfunction

    function automatic tlb_search_req_t random_req();
        logic [31:0] rnd;
        rnd = rand32();
        return make_req(rnd[18:0], rnd[19], rnd[29:20]);
    endfunction

    // request aimed at a known entry, any asid works for a global one
    function automatic tlb_search_req_t hit_req(input tlb_entry_t ent);
        logic [31:0]     rnd;
        tlb_search_req_t q;
        rnd = rand32();
        q   = make_req(ent.vppn, rnd[9], ent.g ? rnd[19:10] : ent.asid);
        if (ent.ps == 6'(ps_2m)) begin
            q.vppn[8:0] = rnd[8:0];
        end
        return q;
    endfunction

    function automatic tlb_entry_t random_entry(input logic [vppn_w-1:0] vppn, input logic is_2m,
                                                input logic g, input logic [asid_w-1:0] asid);
        tlb_entry_t ent;
        logic [31:0] rnd0;
        logic [31:0] rnd1;
        rnd0       = rand32();
        rnd1       = rand32();
        ent.e      = 1'b1;
        ent.vppn   = vppn;
        ent.ps     = is_2m ? 6'(ps_2m) : 6'(ps_4k);
        ent.g      = g;
        ent.asid   = asid;
        ent.page0  = tlb_page_t'(rnd0[25:0]);
        ent.page1  = tlb_page_t'(rnd1[25:0]);
        return ent;
    endfunction

    task automatic write_entry(input int idx, input tlb_entry_t ent);
        @(posedge aclk);
        tlb_we  <= 1'b1;
        w_index <= idx[tlb_idx_w-1:0];
        w_entry <= ent;
        written[idx] = ent;
        @(posedge aclk);
        tlb_we  <= 1'b0;
    endtask

    // full compares the whole entry, otherwise e must read 0
    task automatic read_back(input int idx, input logic full);
        @(posedge aclk);
        r_index <= idx[tlb_idx_w-1:0];
        @(negedge aclk);
        if (full && r_entry !== written[idx]) begin
            $display("Error r_entry[%0d]: expected %h, got %h", idx, written[idx], r_entry);
            errors++;
        end else if (!full && r_entry.e !== 1'b0) begin
            $display("Error r_entry.e[%0d]: expected 0, got %h", idx, r_entry.e);
            errors++;
        end
    endtask

    task automatic search(input tlb_search_req_t q0, input tlb_search_req_t q1);
        @(posedge aclk);
        s0_req <= q0;
        s1_req <= q1;
    endtask

    // operands come from whatever s1_req holds
    task automatic invalidate(input logic [4:0] op);
        @(posedge aclk);
        invtlb_valid <= 1'b1;
        invtlb_op    <= invtlb_op_e'(op);
        @(posedge aclk);
        invtlb_valid <= 1'b0;
    endtask

    task automatic probe(input int idx);
        @(posedge aclk);
        r_index <= idx[tlb_idx_w-1:0];
        s0_req  <= make_req(written[idx].vppn, 1'b0, written[idx].asid);
        s1_req  <= make_req(written[idx].vppn, 1'b1, written[idx].asid);
    endtask

    initial begin
        reset        = 1'b1;
        s0_req       = '0;
        s1_req       = '0;
        tlb_we       = 1'b0;
        w_index      = '0;
        w_entry      = '0;
        r_index      = '0;
        invtlb_valid = 1'b0;
        invtlb_op    = inv_all0;
        repeat (2) @(posedge aclk);
        reset <= 1'b0;

        for (int i = 0; i < 8; i++) search(random_req(), random_req());
        for (int i = 0; i < tlb_num; i++) read_back(i, 1'b0);

        // fill every entry with random 4 KB and 2 MB contents
        for (int i = 0; i < tlb_num; i++) begin
            r = rand32();
            write_entry(i, random_entry(r[18:0], r[19], r[20], r[30:21]));
        end
        for (int i = 0; i < tlb_num; i++) read_back(i, 1'b1);

        // 4 KB pages, asid filtering and a global entry
        r      = rand32();
        va     = r[18:0];
        asid_a = r[28:19];
        write_entry(3, random_entry(va, 1'b0, 1'b0, asid_a));
        search(make_req(va, 1'b0, asid_a), make_req(va, 1'b1, asid_a));
        search(make_req(va, 1'b1, asid_a), make_req(va, 1'b0, asid_a ^ 10'h1));
        r = rand32();
        write_entry(4, random_entry(r[18:0], 1'b0, 1'b1, asid_a));
        search(make_req(r[18:0], 1'b0, r[29:20]), make_req(r[18:0], 1'b1, ~asid_a));

        // 2 MB pages, then two overlapping pairs where index 8 wins
        r  = rand32();
        va = r[18:0];
        write_entry(6, random_entry(va, 1'b1, 1'b0, asid_a));
        search(make_req({va[18:9], 1'b0, r[26:19]}, 1'b0, asid_a),
               make_req({va[18:9], 1'b1, r[27:20]}, 1'b1, asid_a));
        r  = rand32();
        va = r[18:0];
        write_entry(10, random_entry(va, 1'b1, 1'b1, asid_a));
        write_entry(8, random_entry(va ^ 19'h1ff, 1'b1, 1'b1, asid_a));
        search(make_req(va, 1'b0, r[28:19]), make_req(va ^ 19'h100, 1'b0, asid_a));

        // independent ports, one hitting while the other mostly misses
        for (int k = 0; k < 40; k++) begin
            r = rand32();
            if (r[0]) begin
                search(hit_req(written[r[4:1]]), random_req());
            end else begin
                search(random_req(), hit_req(written[r[4:1]]));
            end
        end
        for (int k = 0; k < tlb_num; k++) search(hit_req(written[k]), hit_req(written[15 - k]));

        // shared vppns and asids so each opcode clears a mixed subset
        for (int op = 0; op < 8; op++) begin
            for (int k = 0; k < 4; k++) begin
                r = rand32();
                pool_vppn[k] = r[18:0];
            end
            r = rand32();
            pool_asid[0] = r[9:0];
            pool_asid[1] = r[19:10];
            for (int i = 0; i < tlb_num; i++) begin
                r  = rand32();
                va = r[9] ? {pool_vppn[i % 4][18:9], r[8:0]} : pool_vppn[i % 4];
                write_entry(i, random_entry(va, r[9], r[10], pool_asid[r[11]]));
            end
            search(make_req(pool_vppn[0], 1'b0, pool_asid[0]),
                   make_req(pool_vppn[0], 1'b1, pool_asid[0]));
            invalidate(op[4:0]);
            for (int i = 0; i < tlb_num; i++) probe(i);
        end

        // reset with every entry still valid and the searches aimed at them
        @(posedge aclk);
        reset <= 1'b1;
        repeat (2) @(posedge aclk);
        reset <= 1'b0;
        for (int i = 0; i < tlb_num; i++) read_back(i, 1'b0);

        @(posedge aclk);
        @(negedge aclk);
        total = errors + DUT.u_chk.fail_count;
        $display("read-back errors: %0d, assertion failures: %0d", errors, DUT.u_chk.fail_count);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/loongarch_pkg.sv
verilog/tlb_pkg.sv
verilog/tlb_store.sv
verilog/tlb_lookup.sv
verilog/tlb_top.sv
test/tlb_chk.sv
test/tlb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tlb_tb -f compile.f -o tlb_sim

# keep running past assertion errors so the testbench prints its summary
./obj_dir/tlb_sim +verilator+error+limit+1000 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
